/* exStage.f */
cpuPkg.sv
operandFormatter.sv
claArith.sv
shiftLogic.sv
resultMerge.sv
exStage.sv
exStage_tb.sv

/* Bender.yml */
package:
  name: exStage

sources:
  - cpuPkg.sv
  - operandFormatter.sv
  - claArith.sv
  - shiftLogic.sv
  - resultMerge.sv
  - exStage.sv
  - target: test
    files:
      - exStage_tb.sv

/* exStage_tb.sv */
`default_nettype none

module exStage_tb;

	// drive inputs this long after the rising edge
	localparam int drvDelay = 5;
	// reset, arith, logic, imm and stream tests, each with one drain cycle
	localparam int testCycles = 5 + (3 * 4 * 24 + 1) + (65 + 1) + (56 + 1) + (40 + 1);
	localparam int cycleLimit = testCycles + 100;

	logic clk;
	logic rstN;
	cpuPkg::exIn_t stim;
	cpuPkg::word_t aluResult;
	cpuPkg::flags_t flags;

	// model state, what the outputs must hold after the next edge
	cpuPkg::word_t expResult;
	cpuPkg::flags_t expFlags;
	logic pending;
	int cycleCount;
	int errorCount;

	exStage uut (
		.clk(clk),
		.rstN(rstN),
		.in(stim),
		.aluResult(aluResult),
		.flags(flags)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////
	// failure reporting
	//////////////////////////////

	task automatic abortRun(input string what);
		errorCount++;
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input cpuPkg::word_t got,
		input cpuPkg::word_t exp);
		if (got !== exp)
			abortRun($sformatf("** Error: %s = %h, expected %h", name, got, exp));
	endtask

	task automatic checkFlags(input cpuPkg::flags_t got, input cpuPkg::flags_t exp);
		if (got !== exp)
			abortRun($sformatf("** Error: flags (n v z) = %h, expected %h", got, exp));
	endtask

	// runaway guard
	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > cycleLimit)
			abortRun($sformatf("timeout: the run went past %0d cycles", cycleLimit));
	end

	//////////////////////////////
	// reference model
	//////////////////////////////

	// upper bit is the mem stage, 01 is writeback
	function automatic cpuPkg::word_t fwdValue(input cpuPkg::fwdSel_t sel,
		input cpuPkg::word_t regData, input cpuPkg::word_t mem, input cpuPkg::word_t wb);
		if (sel[1])
			return mem;
		else if (sel == 2'b01)
			return wb;
		return regData;
	endfunction

	function automatic cpuPkg::word_t expectResult(input cpuPkg::exIn_t bundle,
		output logic ovf);
		cpuPkg::opcode_t op;
		cpuPkg::word_t a;
		cpuPkg::word_t b;
		cpuPkg::word_t sext;
		cpuPkg::word_t res;
		logic [3:0] amt;
		logic [31:0] twice;
		int s;
		op = bundle.instr[15:12];
		a = fwdValue(bundle.forwardA, bundle.regData1, bundle.memResult, bundle.writeData);
		b = fwdValue(bundle.forwardB, bundle.regData2, bundle.memResult, bundle.writeData);
		amt = bundle.instr[3:0];
		sext = {{12{bundle.instr[3]}}, bundle.instr[3:0]};
		ovf = 1'b0;
		res = '0;
		case (op)
			cpuPkg::opAdd, cpuPkg::opSub: begin
				if (op == cpuPkg::opAdd)
					s = int'($signed(a)) + int'($signed(b));
				else
					s = int'($signed(a)) - int'($signed(b));
				// clamp to the signed 16-bit range
				if (s > 32767) begin
					res = 16'h7fff;
					ovf = 1'b1;
				end else if (s < -32768) begin
					res = 16'h8000;
					ovf = 1'b1;
				end else begin
					res = cpuPkg::word_t'(s);
				end
			end
			cpuPkg::opRed: begin
				s = int'($signed(a[15:8])) + int'($signed(a[7:0]))
					+ int'($signed(b[15:8])) + int'($signed(b[7:0]));
				res = cpuPkg::word_t'(s);
			end
			cpuPkg::opXor: res = a ^ b;
			cpuPkg::opSll: res = a << amt;
			cpuPkg::opSra: res = cpuPkg::word_t'($signed(a) >>> amt);
			cpuPkg::opRor: begin
				twice = {a, a} >> amt;
				res = twice[15:0];
			end
			cpuPkg::opPaddsb: begin
				// four lanes, each clamped to -8..7
				for (int n = 0; n < 4; n++) begin
					s = int'($signed(a[4*n +: 4])) + int'($signed(b[4*n +: 4]));
					if (s > 7)
						s = 7;
					else if (s < -8)
						s = -8;
					res[4*n +: 4] = s[3:0];
				end
			end
			cpuPkg::opLw, cpuPkg::opSw: res = a + (sext << 1);
			cpuPkg::opLhb: res = {bundle.instr[7:0], a[7:0]};
			cpuPkg::opLlb: res = {a[15:8], bundle.instr[7:0]};
			cpuPkg::opPcs: res = bundle.pcPlus2;
			default: res = '0;
		endcase
		return res;
	endfunction

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////

	// random side data, register file selected on both ports
	function automatic cpuPkg::exIn_t makeBundle(input cpuPkg::opcode_t op,
		input logic [11:0] low, input logic valid);
		cpuPkg::exIn_t b;
		b.valid = valid;
		b.instr = {op, low};
		b.regData1 = cpuPkg::word_t'($urandom());
		b.regData2 = cpuPkg::word_t'($urandom());
		b.pcPlus2 = cpuPkg::word_t'($urandom());
		b.memResult = cpuPkg::word_t'($urandom());
		b.writeData = cpuPkg::word_t'($urandom());
		b.forwardA = 2'b00;
		b.forwardB = 2'b00;
		return b;
	endfunction

	// put each operand where its select points, selects must differ unless 00
	function automatic cpuPkg::exIn_t placeOperands(input cpuPkg::exIn_t b,
		input cpuPkg::fwdSel_t fa, input cpuPkg::fwdSel_t fb,
		input cpuPkg::word_t aVal, input cpuPkg::word_t bVal);
		b.forwardA = fa;
		b.forwardB = fb;
		if (fb[1])
			b.memResult = bVal;
		else if (fb[0])
			b.writeData = bVal;
		else
			b.regData2 = bVal;
		if (fa[1])
			b.memResult = aVal;
		else if (fa[0])
			b.writeData = aVal;
		else
			b.regData1 = aVal;
		return b;
	endfunction

	task automatic checkOutputs();
		checkWord("aluResult", aluResult, expResult);
		checkFlags(flags, expFlags);
	endtask

	// check the previous bundle, then apply the next one
	task automatic step(input cpuPkg::exIn_t bundle);
		logic ovf;
		cpuPkg::opcode_t op;
		@(posedge clk);
		#drvDelay;
		if (pending)
			checkOutputs();
		stim = bundle;
		expResult = expectResult(bundle, ovf);
		op = bundle.instr[15:12];
		if (bundle.valid) begin
			if ((op == cpuPkg::opAdd) || (op == cpuPkg::opSub)) begin
				expFlags.n = expResult[15];
				expFlags.v = ovf;
				expFlags.z = (expResult == '0);
			end else if ((op == cpuPkg::opXor) || (op == cpuPkg::opSll)
				|| (op == cpuPkg::opSra) || (op == cpuPkg::opRor)) begin
				expFlags.z = (expResult == '0);
			end
		end
		pending = 1'b1;
	endtask

	// last check of a test, then park on a bubble
	task automatic drain();
		@(posedge clk);
		#drvDelay;
		checkOutputs();
		stim.valid = 1'b0;
		pending = 1'b0;
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////

	task automatic testReset();
		repeat (5) begin
			@(posedge clk);
			#drvDelay;
			checkWord("aluResult", aluResult, '0);
			checkFlags(flags, '0);
		end
		rstN = 1'b1;
		expResult = '0;
		expFlags = '0;
	endtask

	task automatic testArith();
		cpuPkg::fwdSel_t srcs [3] = '{2'b00, 2'b01, 2'b10};
		cpuPkg::opcode_t ops [4] = '{cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opRed,
			cpuPkg::opPaddsb};
		cpuPkg::word_t edges [4] = '{16'h7fff, 16'h8000, 16'h0001, 16'hffff};
		for (int s = 0; s < 3; s++) begin
			for (int o = 0; o < 4; o++) begin
				// every pairing of the edge values
				for (int i = 0; i < 16; i++)
					step(placeOperands(makeBundle(ops[o], 12'($urandom()), 1'b1),
						srcs[s], srcs[(s + 1) % 3], edges[i / 4], edges[i % 4]));
				for (int r = 0; r < 8; r++)
					step(placeOperands(makeBundle(ops[o], 12'($urandom()), 1'b1),
						srcs[s], srcs[(s + 1) % 3], 16'($urandom()), 16'($urandom())));
			end
		end
		drain();
	endtask

	task automatic testLogic();
		cpuPkg::opcode_t ops [4] = '{cpuPkg::opXor, cpuPkg::opSll, cpuPkg::opSra,
			cpuPkg::opRor};
		cpuPkg::word_t aVal;
		cpuPkg::word_t bVal;
		// saturating sub leaves N and V set, the logic ops must keep them
		step(placeOperands(makeBundle(cpuPkg::opSub, 12'h000, 1'b1), 2'b00, 2'b00,
			16'h8000, 16'h0001));
		for (int o = 0; o < 4; o++) begin
			for (int amt = 0; amt < 16; amt++) begin
				aVal = (amt == 5) ? 16'h0000 : 16'($urandom());
				bVal = (amt == 9) ? aVal : 16'($urandom());
				step(placeOperands(makeBundle(ops[o], {8'($urandom()), 4'(amt)}, 1'b1),
					2'b00, 2'b00, aVal, bVal));
			end
		end
		drain();
	endtask

	task automatic testImm();
		cpuPkg::fwdSel_t srcs [3] = '{2'b00, 2'b01, 2'b10};
		for (int imm = 0; imm < 16; imm++) begin
			step(placeOperands(makeBundle(cpuPkg::opLw, {8'($urandom()), 4'(imm)}, 1'b1),
				srcs[imm % 3], 2'b00, 16'($urandom()), 16'($urandom())));
			step(placeOperands(makeBundle(cpuPkg::opSw, {8'($urandom()), 4'(imm)}, 1'b1),
				srcs[imm % 3], 2'b00, 16'($urandom()), 16'($urandom())));
		end
		for (int r = 0; r < 8; r++) begin
			step(makeBundle(cpuPkg::opLhb, 12'($urandom()), 1'b1));
			step(makeBundle(cpuPkg::opLlb, 12'($urandom()), 1'b1));
			step(makeBundle(cpuPkg::opPcs, 12'($urandom()), 1'b1));
		end
		drain();
	endtask

	task automatic testStream();
		// branch and hlt results are undefined, left out
		cpuPkg::opcode_t legal [13] = '{cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opRed,
			cpuPkg::opXor, cpuPkg::opSll, cpuPkg::opSra, cpuPkg::opRor, cpuPkg::opPaddsb,
			cpuPkg::opLw, cpuPkg::opSw, cpuPkg::opLhb, cpuPkg::opLlb, cpuPkg::opPcs};
		cpuPkg::exIn_t b;
		for (int r = 0; r < 40; r++) begin
			// roughly one in three is a bubble
			b = makeBundle(legal[$urandom() % 13], 12'($urandom()), ($urandom() % 3) != 0);
			b.forwardA = 2'($urandom());
			b.forwardB = 2'($urandom());
			step(b);
		end
		drain();
	endtask

	initial begin
		void'($urandom(48));
		rstN = 1'b0;
		stim = '0;
		expResult = '0;
		expFlags = '0;
		pending = 1'b0;
		cycleCount = 0;
		errorCount = 0;
		testReset();
		testArith();
		testLogic();
		testImm();
		testStream();
		if (errorCount == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* exStage.sv */
`default_nettype none

module exStage (
	input logic clk,
	input logic rstN,
	input cpuPkg::exIn_t in,
	output cpuPkg::word_t aluResult,
	output cpuPkg::flags_t flags
);

	// formatter outputs, fanned out to both units
	cpuPkg::operands_t operands;
	cpuPkg::aluOp_t aluOp;

	// unit results into the merge
	cpuPkg::word_t claResult;
	logic claOverflow;
	cpuPkg::word_t shiftResult;
	cpuPkg::word_t xorResult;

	operandFormatter uFormatter (
		.in(in),
		.operands(operands),
		.aluOp(aluOp)
	);

	claArith uCla (
		.operands(operands),
		.aluOp(aluOp),
		.claResult(claResult),
		.claOverflow(claOverflow)
	);

	shiftLogic uShift (
		.operands(operands),
		.aluOp(aluOp),
		.shiftResult(shiftResult),
		.xorResult(xorResult)
	);

	// only registered block, one cycle from bundle to result
	resultMerge uMerge (
		.clk(clk),
		.rstN(rstN),
		.valid(in.valid),
		.opcode(in.instr[15:12]),
		.aluOp(aluOp),
		.claResult(claResult),
		.claOverflow(claOverflow),
		.shiftResult(shiftResult),
		.xorResult(xorResult),
		.aluResult(aluResult),
		.flags(flags)
	);

endmodule

`default_nettype wire

/* resultMerge.sv */
`default_nettype none

module resultMerge (
	input logic clk,
	input logic rstN,
	input logic valid,
	input cpuPkg::opcode_t opcode,
	input cpuPkg::aluOp_t aluOp,
	input cpuPkg::word_t claResult,
	input logic claOverflow,
	input cpuPkg::word_t shiftResult,
	input cpuPkg::word_t xorResult,
	output cpuPkg::word_t aluResult,
	output cpuPkg::flags_t flags
);

	logic isAddSub;
	logic isLogic;
	cpuPkg::word_t claSat;
	cpuPkg::word_t selResult;

	// which flags an opcode touches
	assign isAddSub = (opcode == cpuPkg::opAdd) || (opcode == cpuPkg::opSub);
	assign isLogic = (opcode == cpuPkg::opXor) || (opcode == cpuPkg::opSll)
		|| (opcode == cpuPkg::opSra) || (opcode == cpuPkg::opRor);

	// add/sub saturate
	// a wrapped result with bit 15 set came from a positive overflow
	assign claSat = (isAddSub && claOverflow)
		? (claResult[15] ? cpuPkg::wordMax : cpuPkg::wordMin)
		: claResult;

	always_comb begin
		case (aluOp.outSel)
			cpuPkg::selXor: selResult = xorResult;
			cpuPkg::selShift: selResult = shiftResult;
			default: selResult = claSat;
		endcase
	end

	//////////////////////////////
	// result and flag registers
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			aluResult <= '0;
			flags <= '0;
		end else begin
			// result loads even on bubbles
			aluResult <= selResult;
			if (valid && isAddSub) begin
				flags.n <= selResult[15];
				flags.v <= claOverflow;
				flags.z <= (selResult == '0);
			end else if (valid && isLogic) begin
				flags.z <= (selResult == '0);
			end
		end
	end

	// decode only ever produces cla, xor or shift
	outSelLegal: assert property (@(posedge clk) disable iff (!rstN)
		aluOp.outSel != 2'b11)
		else $error("resultMerge: outSel is 3");

endmodule

`default_nettype wire

/* shiftLogic.sv */
`default_nettype none

module shiftLogic (
	input cpuPkg::operands_t operands,
	input cpuPkg::aluOp_t aluOp,
	output cpuPkg::word_t shiftResult,
	output cpuPkg::word_t xorResult
);

	logic [3:0] shAmt;
	// stage[k] is the value after the first k stages
	cpuPkg::word_t stage [0:4];

	// amount is the low nibble of B, the formatter puts instr[3:0] there
	assign shAmt = operands.bOp[3:0];
	assign stage[0] = operands.aOp;

	//////////////////////////////
	// log shifter
	//////////////////////////////

	// stage k moves by 1 << k when amount bit k is set
	for (genvar k = 0; k < 4; k++) begin : gStage
		always_comb begin
			if (!shAmt[k]) begin
				stage[k+1] = stage[k];
			end else begin
				case (aluOp.shiftOp)
					cpuPkg::shSll:
						stage[k+1] = stage[k] << (1 << k);
					cpuPkg::shSra:
						stage[k+1] = cpuPkg::word_t'($signed(stage[k]) >>> (1 << k));
					default:
						// ror, bits falling off the bottom wrap to the top
						stage[k+1] = (stage[k] >> (1 << k))
							| (stage[k] << (cpuPkg::wordWidth - (1 << k)));
				endcase
			end
		end
	end

	assign shiftResult = stage[4];

	// xor shares nothing with the shifter
	assign xorResult = operands.aOp ^ operands.bOp;

endmodule

`default_nettype wire

/* claArith.sv */
`default_nettype none

module claArith (
	input cpuPkg::operands_t operands,
	input cpuPkg::aluOp_t aluOp,
	output cpuPkg::word_t claResult,
	output logic claOverflow
);

	// one 4-bit lookahead group
	// returns {group generate, group propagate, sum}
	function automatic logic [5:0] claGroup(
		input logic [3:0] a,
		input logic [3:0] b,
		input logic cin
	);
		logic [3:0] g;
		logic [3:0] p;
		logic [3:0] c;
		logic grpGen;
		logic grpProp;
		g = a & b;
		p = a ^ b;
		c[0] = cin;
		c[1] = g[0] | (p[0] & c[0]);
		c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & c[0]);
		c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & c[0]);
		grpGen = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) | (p[3] & p[2] & p[1] & g[0]);
		grpProp = &p;
		return {grpGen, grpProp, p ^ c};
	endfunction

	cpuPkg::word_t a;
	cpuPkg::word_t b;
	cpuPkg::word_t sum;
	cpuPkg::word_t nibSum;
	cpuPkg::word_t redSum;
	logic [3:0] grpG;
	logic [3:0] grpP;
	logic [3:0] grpC;
	logic [3:0] nibCin;
	logic [3:0] nibOvf;
	logic sumOvf;
	logic signed [8:0] redA;
	logic signed [8:0] redB;
	logic signed [9:0] redTotal;

	assign a = operands.aOp;
	// subtract as a + ~b + 1
	assign b = aluOp.sub ? ~operands.bOp : operands.bOp;

	//////////////////////////////
	// lookahead adder
	//////////////////////////////

	always_comb begin
		logic [5:0] grp;
		for (int i = 0; i < 4; i++) begin
			grp = claGroup(a[4*i +: 4], b[4*i +: 4], 1'b0);
			grpG[i] = grp[5];
			grpP[i] = grp[4];
		end
	end

	// second level lookahead across the groups
	assign grpC[0] = aluOp.sub;
	assign grpC[1] = grpG[0] | (grpP[0] & grpC[0]);
	assign grpC[2] = grpG[1] | (grpP[1] & grpG[0]) | (grpP[1] & grpP[0] & grpC[0]);
	assign grpC[3] = grpG[2] | (grpP[2] & grpG[1]) | (grpP[2] & grpP[1] & grpG[0])
		| (grpP[2] & grpP[1] & grpP[0] & grpC[0]);

	// paddsb breaks the chain at every nibble
	assign nibCin = aluOp.sat ? 4'b0000 : grpC;

	always_comb begin
		logic [5:0] grp;
		for (int i = 0; i < 4; i++) begin
			grp = claGroup(a[4*i +: 4], b[4*i +: 4], nibCin[i]);
			sum[4*i +: 4] = grp[3:0];
		end
	end

	// signed overflow of the full word
	assign sumOvf = (a[15] == b[15]) && (sum[15] != a[15]);

	// per nibble clamp to +7 / -8
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			nibOvf[i] = (a[4*i+3] == b[4*i+3]) && (sum[4*i+3] != a[4*i+3]);
			if (nibOvf[i])
				nibSum[4*i +: 4] = a[4*i+3] ? 4'h8 : 4'h7;
			else
				nibSum[4*i +: 4] = sum[4*i +: 4];
		end
	end

	//////////////////////////////
	// red reduction tree
	//////////////////////////////

	// byte pairs first, then the two partial sums
	assign redA = $signed(operands.aOp[15:8]) + $signed(operands.aOp[7:0]);
	assign redB = $signed(operands.bOp[15:8]) + $signed(operands.bOp[7:0]);
	assign redTotal = redA + redB;
	assign redSum = {{6{redTotal[9]}}, redTotal};

	// plain sums go out wrapped
	// the 16-bit clamp for add and sub comes with the overflow bit
	assign claResult = aluOp.red ? redSum : (aluOp.sat ? nibSum : sum);
	assign claOverflow = aluOp.sat ? |nibOvf : (!aluOp.red && sumOvf);

	// formatter must never ask for both split modes at once
	satRedExclusive: assert final ($isunknown(aluOp) || !(aluOp.sat && aluOp.red))
		else $error("claArith: sat and red set together");

endmodule

`default_nettype wire

/* operandFormatter.sv */
`default_nettype none

module operandFormatter (
	input cpuPkg::exIn_t in,
	output cpuPkg::operands_t operands,
	output cpuPkg::aluOp_t aluOp
);

	// forwarding tree, mem-stage result wins over writeback
	function automatic cpuPkg::word_t forwardMux(
		input cpuPkg::fwdSel_t sel,
		input cpuPkg::word_t regData,
		input cpuPkg::word_t memResult,
		input cpuPkg::word_t writeData
	);
		if (sel[1])
			return memResult;
		if (sel[0])
			return writeData;
		return regData;
	endfunction

	cpuPkg::opcode_t opcode;

	// internal formatting controls
	logic useImm;
	logic byteSel;
	logic memOp;
	logic pcsSel;
	logic ldByte;

	cpuPkg::word_t regA;
	cpuPkg::word_t regB;
	cpuPkg::word_t byteA;
	cpuPkg::word_t byteB;
	cpuPkg::word_t immMem;
	cpuPkg::word_t imm;

	assign opcode = in.instr[15:12];

	//////////////////////////////
	// decode
	//////////////////////////////

	// lw and sw need the doubled offset
	assign memOp = (opcode == cpuPkg::opLw) || (opcode == cpuPkg::opSw);
	assign ldByte = (opcode == cpuPkg::opLhb) || (opcode == cpuPkg::opLlb);
	// 1 for llb, 0 for lhb
	assign byteSel = opcode[0];
	assign pcsSel = (opcode == cpuPkg::opPcs);
	// immediate for shifts, memory ops and byte loads
	assign useImm = memOp || ldByte
		|| (opcode == cpuPkg::opSll)
		|| (opcode == cpuPkg::opSra)
		|| (opcode == cpuPkg::opRor);

	// control word for the two units
	always_comb begin
		aluOp.outSel = cpuPkg::selCla;
		if (opcode == cpuPkg::opXor)
			aluOp.outSel = cpuPkg::selXor;
		else if ((opcode == cpuPkg::opSll) || (opcode == cpuPkg::opSra)
			|| (opcode == cpuPkg::opRor))
			aluOp.outSel = cpuPkg::selShift;
		aluOp.sat = (opcode == cpuPkg::opPaddsb);
		aluOp.red = (opcode == cpuPkg::opRed);
		aluOp.sub = (opcode == cpuPkg::opSub);
		// shifter mode straight from the opcode
		aluOp.shiftOp = opcode[1:0];
	end

	//////////////////////////////
	// operand A
	//////////////////////////////

	assign regA = forwardMux(in.forwardA, in.regData1, in.memResult, in.writeData);
	// clear the byte that the immediate lands in
	assign byteA = byteSel ? {regA[15:8], 8'h00} : {8'h00, regA[7:0]};
	// pcs is a plain add of zero and pc+2
	assign operands.aOp = pcsSel ? '0 : (ldByte ? byteA : regA);

	//////////////////////////////
	// operand B
	//////////////////////////////

	assign regB = forwardMux(in.forwardB, in.regData2, in.memResult, in.writeData);
	// byte immediate into the target byte
	assign byteB = byteSel ? {8'h00, in.instr[7:0]} : {in.instr[7:0], 8'h00};
	// sign extend, memory offsets count half-words
	assign immMem = memOp ? {{11{in.instr[3]}}, in.instr[3:0], 1'b0}
		: {{12{in.instr[3]}}, in.instr[3:0]};
	assign imm = ldByte ? byteB : immMem;
	assign operands.bOp = pcsSel ? in.pcPlus2 : (useImm ? imm : regB);

endmodule

`default_nettype wire

/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

	////////////////////////////////
	// widths
	////////////////////////////////

	localparam int wordWidth = 16;
	localparam int opcodeWidth = 4;

	// data word, instruction word and the opcode field
	typedef logic [wordWidth-1:0] word_t;
	typedef logic [wordWidth-1:0] instr_t;
	typedef logic [opcodeWidth-1:0] opcode_t;

	// forwarding select
	// upper bit set picks the mem-stage alu result, 01 picks writeback data
	typedef logic [1:0] fwdSel_t;

	////////////////////////////////
	// opcodes
	////////////////////////////////

	localparam opcode_t opAdd = 4'd0;
	localparam opcode_t opSub = 4'd1;
	localparam opcode_t opRed = 4'd2;
	localparam opcode_t opXor = 4'd3;
	localparam opcode_t opSll = 4'd4;
	localparam opcode_t opSra = 4'd5;
	localparam opcode_t opRor = 4'd6;
	localparam opcode_t opPaddsb = 4'd7;
	localparam opcode_t opLw = 4'd8;
	localparam opcode_t opSw = 4'd9;
	localparam opcode_t opLhb = 4'd10;
	localparam opcode_t opLlb = 4'd11;
	localparam opcode_t opB = 4'd12;
	localparam opcode_t opBr = 4'd13;
	localparam opcode_t opPcs = 4'd14;
	localparam opcode_t opHlt = 4'd15;

	// which unit drives the result
	localparam logic [1:0] selCla = 2'd0;
	localparam logic [1:0] selXor = 2'd1;
	localparam logic [1:0] selShift = 2'd2;

	// shifter modes, same as the low opcode bits of sll/sra/ror
	localparam logic [1:0] shSll = 2'd0;
	localparam logic [1:0] shSra = 2'd1;
	localparam logic [1:0] shRor = 2'd2;

	// signed 16-bit clamp values
	localparam word_t wordMax = 16'h7fff;
	localparam word_t wordMin = 16'h8000;

	////////////////////////////////
	// bundles
	////////////////////////////////

	// alu control word, same bit order as {outSel, sat, red, sub, shiftOp}
	typedef struct packed {
		logic [1:0] outSel;
		logic sat;
		logic red;
		logic sub;
		logic [1:0] shiftOp;
	} aluOp_t;

	typedef struct packed {
		word_t aOp;
		word_t bOp;
	} operands_t;

	typedef struct packed {
		logic n;
		logic v;
		logic z;
	} flags_t;

	// everything the stage takes in from decode and forwarding
	typedef struct packed {
		logic valid;
		instr_t instr;
		word_t regData1;
		word_t regData2;
		word_t pcPlus2;
		word_t memResult;
		word_t writeData;
		fwdSel_t forwardA;
		fwdSel_t forwardB;
	} exIn_t;

endpackage

`default_nettype wire
